// ==== all.f ====
+incdir+dv
src/slave_cfg_pkg.sv
src/axi_proto_pkg.sv
src/slave_mem.sv
src/write_engine.sv
src/read_engine.sv
src/axi_slave_top.sv
dv/tb_axi_slave.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_axi_slave
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only --timing --assert -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

task automatic mismatch_error(input string what, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
  errors++;
  $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
endtask

task automatic protocol_error(input string what);
  errors++;
  $display("Failure in %s: %s", test_name, what);
endtask

// word address of a beat, from the burst rules
function automatic logic [ADDR_W-1:0] expected_addr(input logic [ADDR_W-1:0] base,
                                                    input burst_e burst, input int beat);
  int a;
  case (burst)
    BURST_INCR: a = (int'(base) + beat) % MEM_DEPTH;
    BURST_WRAP: a = (int'(base) / WRAP_BEATS) * WRAP_BEATS + (int'(base) + beat) % WRAP_BEATS;
    default:    a = int'(base);
  endcase
  return ADDR_W'(a);
endfunction

function automatic bit chan_up(input string ch);
  case (ch)
    "aw":    return awready;
    "w":     return wready;
    "b":     return bvalid;
    "ar":    return arready;
    default: return rvalid;
  endcase
endfunction

// ends 2 ns after the edge that made the transfer
task automatic wait_chan(input string ch);
  int t;
  t = 0;
  if (timed_out) return;
  @(negedge aclk);
  while (!chan_up(ch)) begin
    t++;
    if (t > WAIT_LIMIT) begin
      $display("Timeout in %s: %s channel did not handshake within %0d cycles",
               test_name, ch, WAIT_LIMIT);
      timed_out = 1'b1;
      return;
    end
    @(negedge aclk);
  end
  @(posedge aclk);
  #2;
endtask

task automatic write_burst(input logic [ADDR_W-1:0] addr, input burst_e burst,
                           input logic [LEN_W-1:0] len, input bit rand_strb,
                           input int b_delay);
  int i;
  int b;
  logic [ADDR_W-1:0] a;
  awid    = SLAVE_ID;
  awaddr  = addr;
  awlen   = len;
  awburst = burst;
  awvalid = 1'b1;
  wait_chan("aw");
  awvalid = 1'b0;
  for (i = 0; i <= int'(len); i++) begin
    wdata = $random(seed);
    wstrb = rand_strb ? STRB_W'($random(seed)) : '1;
    if (wstrb == '0) wstrb = STRB_W'(1);
    wvalid = 1'b1;
    wait_chan("w");
    // reserved bursts leave the model untouched
    a = expected_addr(addr, burst, i);
    if (burst != BURST_RSVD) begin
      for (b = 0; b < STRB_W; b++) begin
        if (wstrb[b]) ref_mem[a][8*b +: 8] = wdata[8*b +: 8];
      end
      ref_written[a] = 1'b1;
    end
  end
  wvalid    = 1'b0;
  exp_bresp = (burst == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;
  if (b_delay > 0) begin
    repeat (b_delay) @(posedge aclk);
    #2;
  end
  bready = 1'b1;
  wait_chan("b");
  bready = 1'b0;
  resps_checked++;
endtask

task automatic read_burst(input logic [ADDR_W-1:0] addr, input burst_e burst,
                          input logic [LEN_W-1:0] len, input int stall);
  int i;
  logic [ADDR_W-1:0] a;
  bit ok;
  arid    = SLAVE_ID;
  araddr  = addr;
  arlen   = len;
  arburst = burst;
  arvalid = 1'b1;
  wait_chan("ar");
  arvalid = 1'b0;
  for (i = 0; i <= int'(len); i++) begin
    a         = expected_addr(addr, burst, i);
    ok        = ref_written[a] && (burst != BURST_RSVD);
    exp_rdata = ok ? ref_mem[a] : '0;
    exp_rresp = ok ? RESP_OKAY : RESP_SLVERR;
    exp_rlast = (i == int'(len));
    // hold off the first beat
    if (i == 0 && stall > 0) begin
      repeat (stall) @(posedge aclk);
      #2;
    end
    rready = 1'b1;
    wait_chan("r");
    beats_checked++;
  end
  rready = 1'b0;
endtask

task automatic check_foreign_id();
  awid    = ID_W'(SLAVE_ID + 1);
  arid    = ID_W'(SLAVE_ID + 1);
  awburst = BURST_INCR;
  arburst = BURST_INCR;
  awvalid = 1'b1;
  arvalid = 1'b1;
  repeat (10) begin
    @(negedge aclk);
    assert (!awready && !arready)
      else protocol_error("request with a foreign ID was accepted");
  end
  @(posedge aclk);
  #2;
  awvalid = 1'b0;
  arvalid = 1'b0;
endtask

`endif

// ==== dv/tb_axi_slave.sv ====
module tb_axi_slave
  import axi_proto_pkg::*, slave_cfg_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 50;

  logic              aclk;
  logic              aresetn;
  logic [ID_W-1:0]   awid;
  logic [ADDR_W-1:0] awaddr;
  logic [LEN_W-1:0]  awlen;
  burst_e            awburst;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  resp_e             bresp;
  logic              bvalid;
  logic              bready;
  logic [ID_W-1:0]   arid;
  logic [ADDR_W-1:0] araddr;
  logic [LEN_W-1:0]  arlen;
  burst_e            arburst;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  resp_e             rresp;
  logic              rlast;
  logic              rvalid;
  logic              rready;

  // reference model of the storage
  logic [DATA_W-1:0]    ref_mem [MEM_DEPTH];
  logic [MEM_DEPTH-1:0] ref_written;
  logic [DATA_W-1:0]    exp_rdata;
  resp_e                exp_rresp;
  logic                 exp_rlast;
  resp_e                exp_bresp;

  string  test_name;
  integer seed;
  int     errors;
  int     beats_checked;
  int     resps_checked;
  bit     timed_out;

  axi_slave_top UUT (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  `include "tb_axi_tasks.svh"

  // --------------------------------------------------------------------------
  // checks on every r and b transfer
  // --------------------------------------------------------------------------
  a_rdata: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && rready |-> rdata == exp_rdata)
    else mismatch_error("rdata", exp_rdata, $sampled(rdata));
  a_rresp: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && rready |-> rresp == exp_rresp)
    else mismatch_error("rresp", DATA_W'(exp_rresp), DATA_W'($sampled(rresp)));
  a_rlast: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && rready |-> rlast == exp_rlast)
    else mismatch_error("rlast", DATA_W'(exp_rlast), DATA_W'($sampled(rlast)));
  a_bresp: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && bready |-> bresp == exp_bresp)
    else mismatch_error("bresp", DATA_W'(exp_bresp), DATA_W'($sampled(bresp)));
  a_r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> $stable(rdata) && $stable(rresp) && $stable(rlast))
    else protocol_error("read beat changed while rready was low");
  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else protocol_error("write response dropped or changed before bready");

  initial begin
    seed = 80597;
    {aresetn, awid, awaddr, awlen, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {arid, araddr, arlen, arvalid, rready} = '0;
    awburst = BURST_INCR;
    arburst = BURST_INCR;
    ref_written = '0;
    for (int i = 0; i < MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    repeat (2) @(posedge aclk);
    #2;
    aresetn = 1'b1;
    test_name = "reset";
    @(negedge aclk);
    assert (awready && arready && !bvalid && !rvalid && !wready)
      else protocol_error("handshake levels wrong after reset");
    @(posedge aclk);
    #2;
    test_name = "incr";
    write_burst(4'd0, BURST_INCR, 4'd7, 1'b0, 0);
    read_burst(4'd0, BURST_INCR, 4'd7, 0);
    test_name = "unwritten";
    read_burst(4'd8, BURST_INCR, 4'd3, 0);
    // fixed and wrap land on words that are already fully written
    test_name = "fixed_wrap";
    write_burst(4'd3, BURST_FIXED, 4'd2, 1'b1, 0);
    write_burst(4'd6, BURST_WRAP, 4'd5, 1'b1, 0);
    read_burst(4'd0, BURST_INCR, 4'd7, 0);
    test_name = "foreign_id";
    check_foreign_id();
    test_name = "reserved";
    write_burst(4'd2, BURST_RSVD, 4'd1, 1'b0, 0);
    read_burst(4'd0, BURST_INCR, 4'd3, 0);
    read_burst(4'd0, BURST_RSVD, 4'd1, 0);
    test_name = "backpressure";
    write_burst(4'd12, BURST_INCR, 4'd3, 1'b0, 5);
    read_burst(4'd12, BURST_INCR, 4'd3, 4);
    $display("Checked %0d read beats and %0d write responses, %0d errors",
             beats_checked, resps_checked, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/axi_slave_top.sv ====
module axi_slave_top
  import axi_proto_pkg::*, slave_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // write address channel
  input  logic [ID_W-1:0]   awid,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic [LEN_W-1:0]  awlen,
  input  burst_e            awburst,
  input  logic              awvalid,
  output logic              awready,
  // write data channel
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  // write response channel
  output resp_e             bresp,
  output logic              bvalid,
  input  logic              bready,
  // read address channel
  input  logic [ID_W-1:0]   arid,
  input  logic [ADDR_W-1:0] araddr,
  input  logic [LEN_W-1:0]  arlen,
  input  burst_e            arburst,
  input  logic              arvalid,
  output logic              arready,
  // read data channel
  output logic [DATA_W-1:0] rdata,
  output resp_e             rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready
);

  logic              mem_wr_en;
  logic [ADDR_W-1:0] mem_wr_addr;
  logic [DATA_W-1:0] mem_wr_data;
  logic [STRB_W-1:0] mem_wr_strb;
  logic [ADDR_W-1:0] mem_rd_addr;
  logic [DATA_W-1:0] mem_rd_data;
  logic              mem_rd_written;

  // ---------------------------------------------------------------------------
  // storage shared by the two independent engines
  // ---------------------------------------------------------------------------
  slave_mem u_mem (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .wr_en      (mem_wr_en),
    .wr_addr    (mem_wr_addr),
    .wr_data    (mem_wr_data),
    .wr_strb    (mem_wr_strb),
    .rd_addr    (mem_rd_addr),
    .rd_data    (mem_rd_data),
    .rd_written (mem_rd_written)
  );

  write_engine u_wr (
    .aclk, .aresetn,
    .awid, .awaddr, .awlen, .awburst, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .mem_wr_en, .mem_wr_addr, .mem_wr_data, .mem_wr_strb
  );

  read_engine u_rd (
    .aclk, .aresetn,
    .arid, .araddr, .arlen, .arburst, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .mem_rd_addr, .mem_rd_data, .mem_rd_written
  );

endmodule

// ==== src/read_engine.sv ====
module read_engine
  import axi_proto_pkg::*, slave_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // read address channel
  input  logic [ID_W-1:0]   arid,
  input  logic [ADDR_W-1:0] araddr,
  input  logic [LEN_W-1:0]  arlen,
  input  burst_e            arburst,
  input  logic              arvalid,
  output logic              arready,
  // read data channel
  output logic [DATA_W-1:0] rdata,
  output resp_e             rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  // memory read port
  output logic [ADDR_W-1:0] mem_rd_addr,
  input  logic [DATA_W-1:0] mem_rd_data,
  input  logic              mem_rd_written
);

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  rd_state_e         state;
  logic [ADDR_W-1:0] base_q;
  logic [LEN_W-1:0]  len_q;
  burst_e            burst_q;
  logic [LEN_W-1:0]  beat_cnt;
  logic [LEN_W-1:0]  nxt_idx;
  logic [ADDR_W-1:0] sel_base;
  burst_e            sel_burst;
  logic [LEN_W-1:0]  sel_idx;
  logic              ar_xfer;
  logic              r_xfer;
  logic              load_beat;
  logic              beat_ok;

  assign arready   = (state == RD_IDLE) && !(arvalid && (arid != SLAVE_ID));
  assign rvalid    = (state == RD_DATA);
  assign ar_xfer   = arvalid && arready;
  assign r_xfer    = rvalid && rready;
  assign load_beat = ar_xfer || (r_xfer && !rlast);
  assign nxt_idx   = beat_cnt + LEN_W'(1);

  // ---------------------------------------------------------------------------
  // address of the beat loaded on the next edge
  // ---------------------------------------------------------------------------

  // beat 0 comes straight from the request while idle
  always_comb begin
    if (state == RD_IDLE) begin
      sel_base  = araddr;
      sel_burst = arburst;
      sel_idx   = '0;
    end else begin
      sel_base  = base_q;
      sel_burst = burst_q;
      sel_idx   = nxt_idx;
    end
  end

  assign mem_rd_addr = beat_addr(sel_base, sel_burst, sel_idx);
  assign beat_ok     = mem_rd_written && (sel_burst != BURST_RSVD);

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state    <= RD_IDLE;
      beat_cnt <= '0;
      rlast    <= 1'b0;
    end else if (ar_xfer) begin
      state    <= RD_DATA;
      beat_cnt <= '0;
      rlast    <= (arlen == '0);
    end else if (r_xfer) begin
      // last beat taken, back to idle
      if (rlast) state <= RD_IDLE;
      beat_cnt <= nxt_idx;
      rlast    <= !rlast && (nxt_idx == len_q);
    end
  end

  // request and beat payload
  always_ff @(posedge aclk) begin
    if (ar_xfer) begin
      base_q  <= araddr;
      len_q   <= arlen;
      burst_q <= arburst;
    end
    if (load_beat) begin
      rdata <= beat_ok ? mem_rd_data : '0;
      rresp <= beat_ok ? RESP_OKAY : RESP_SLVERR;
    end
  end

endmodule

// ==== src/write_engine.sv ====
module write_engine
  import axi_proto_pkg::*, slave_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // write address channel
  input  logic [ID_W-1:0]   awid,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic [LEN_W-1:0]  awlen,
  input  burst_e            awburst,
  input  logic              awvalid,
  output logic              awready,
  // write data channel
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  // write response channel
  output resp_e             bresp,
  output logic              bvalid,
  input  logic              bready,
  // memory write port
  output logic              mem_wr_en,
  output logic [ADDR_W-1:0] mem_wr_addr,
  output logic [DATA_W-1:0] mem_wr_data,
  output logic [STRB_W-1:0] mem_wr_strb
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP,
    WR_DONE
  } wr_state_e;

  wr_state_e         state;
  wr_state_e         state_nxt;
  logic [ADDR_W-1:0] base_q;
  logic [LEN_W-1:0]  len_q;
  burst_e            burst_q;
  logic [LEN_W-1:0]  beat_cnt;
  logic              aw_xfer;
  logic              w_xfer;
  logic              last_beat;

  // ---------------------------------------------------------------------------
  // handshake levels
  // ---------------------------------------------------------------------------

  // a foreign ID holds awready low, so that request is never taken
  assign awready   = (state == WR_IDLE) && !(awvalid && (awid != SLAVE_ID));
  assign wready    = (state == WR_DATA);
  assign bvalid    = (state == WR_RESP);
  assign aw_xfer   = awvalid && awready;
  assign w_xfer    = wvalid && wready;
  assign last_beat = (beat_cnt == len_q);

  always_comb begin
    state_nxt = state;
    case (state)
      WR_IDLE: if (aw_xfer) state_nxt = WR_DATA;
      WR_DATA: if (w_xfer && last_beat) state_nxt = WR_RESP;
      WR_RESP: if (bready) state_nxt = WR_DONE;
      // one turnaround cycle before the next address
      WR_DONE: state_nxt = WR_IDLE;
      default: state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state    <= WR_IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (aw_xfer) begin
        beat_cnt <= '0;
      end else if (w_xfer) begin
        beat_cnt <= beat_cnt + LEN_W'(1);
      end
    end
  end

  // burst request held for the whole data phase
  always_ff @(posedge aclk) begin
    if (aw_xfer) begin
      base_q  <= awaddr;
      len_q   <= awlen;
      burst_q <= awburst;
    end
  end

  // ---------------------------------------------------------------------------
  // memory side and response
  // ---------------------------------------------------------------------------

  // reserved bursts drain their beats without storing
  assign mem_wr_en   = w_xfer && (burst_q != BURST_RSVD);
  assign mem_wr_addr = beat_addr(base_q, burst_q, beat_cnt);
  assign mem_wr_data = wdata;
  assign mem_wr_strb = wstrb;

  assign bresp = (burst_q == BURST_RSVD) ? RESP_SLVERR : RESP_OKAY;

endmodule

// ==== src/slave_mem.sv ====
module slave_mem
  import axi_proto_pkg::*, slave_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              aresetn,
  // write port
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic [STRB_W-1:0] wr_strb,
  // read port, combinational
  input  logic [ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0] rd_data,
  output logic              rd_written
);

  logic [DATA_W-1:0]    mem [MEM_DEPTH];
  logic [MEM_DEPTH-1:0] written;

  // byte lanes follow the strobe
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // set on any write, even with an empty strobe
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      written <= '0;
    end else if (wr_en) begin
      written[wr_addr] <= 1'b1;
    end
  end

  assign rd_data    = mem[rd_addr];
  assign rd_written = written[rd_addr];

endmodule

// ==== src/axi_proto_pkg.sv ====
package axi_proto_pkg;
  import slave_cfg_pkg::*;

  // ---------------------------------------------------------------------------
  // bus widths
  // ---------------------------------------------------------------------------
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int LEN_W  = 4;
  localparam int ID_W   = 2;

  // address bits that move inside a wrap block
  localparam int WRAP_W = $clog2(WRAP_BEATS);

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10,
    BURST_RSVD  = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // word address of beat idx in a burst starting at base
  function automatic logic [ADDR_W-1:0] beat_addr(
    input logic [ADDR_W-1:0] base,
    input burst_e            burst,
    input logic [LEN_W-1:0]  idx
  );
    logic [WRAP_W-1:0] low;
    low = base[WRAP_W-1:0] + idx[WRAP_W-1:0];
    case (burst)
      BURST_INCR: return base + ADDR_W'(idx);
      BURST_WRAP: return {base[ADDR_W-1:WRAP_W], low};
      // fixed, and reserved which never stores anyway
      default:    return base;
    endcase
  endfunction

endpackage

// ==== src/slave_cfg_pkg.sv ====
package slave_cfg_pkg;

  // ---------------------------------------------------------------------------
  // identity and size of this slave
  // ---------------------------------------------------------------------------

  // ID accepted on both aw and ar
  localparam logic [1:0] SLAVE_ID = 2'd1;

  // word storage
  localparam int MEM_DEPTH = 16;
  localparam int ADDR_W    = $clog2(MEM_DEPTH);

  // wrap bursts stay inside a block of this many words
  localparam int WRAP_BEATS = 4;

endpackage
